/* include/mem_map.svh */
// Data bus address map: target select bit, timer offset width and timer register offsets
`ifndef MEM_MAP_SVH
`define MEM_MAP_SVH

// Address bit that picks the timer over the RAM
`define MMIO_SEL_BIT 28

// Timer register offsets, taken from the low address bits
`define TMR_OFF_W    4
`define TMR_CTRL     4'h0
`define TMR_MTIME    4'h4
`define TMR_MTIMECMP 4'h8
// Bit 0 mirrors the interrupt level
`define TMR_STATUS   4'hC

`endif

/* hw/riscv_defines.sv */
// Package: word width, bus vector types, byte-enable patterns, load/store encodings
package riscv_defines;

	//////////////////////////////
	// Widths and vector types
	//////////////////////////////

	localparam int unsigned WORD_WIDTH = 32;
	localparam int unsigned BE_WIDTH   = WORD_WIDTH / 8;

	// Data or address word
	typedef logic [WORD_WIDTH-1:0] word_t;
	// One enable bit per byte lane
	typedef logic [BE_WIDTH-1:0]   be_t;
	// Commands from the writeback stage
	typedef logic [2:0]            load_type_t;
	typedef logic [1:0]            store_type_t;

	// Lane patterns, always based at lane 0
	localparam be_t BE_NONE = 4'b0000;
	localparam be_t BE_BYTE = 4'b0001;
	localparam be_t BE_HALF = 4'b0011;
	localparam be_t BE_WORD = 4'b1111;

	//////////////////////////////
	// Load/store encodings
	//////////////////////////////

	// Signed loads
	localparam load_type_t LD_LB  = 3'b001;
	localparam load_type_t LD_LH  = 3'b010;
	localparam load_type_t LD_LW  = 3'b100;
	// Unsigned loads
	localparam load_type_t LD_LBU = 3'b101;
	localparam load_type_t LD_LHU = 3'b110;

	// Stores
	localparam store_type_t ST_SB = 2'b01;
	localparam store_type_t ST_SH = 2'b10;
	localparam store_type_t ST_SW = 2'b11;

endpackage

/* hw/mem_bus_if.sv */
// Data memory bus interface: req/gnt/rvalid signals with master and slave modports
`timescale 1ns/1ps

interface mem_bus_if;
	import riscv_defines::*;

	// Request, driven by the master
	logic  req;
	word_t addr;
	logic  we;
	be_t   be;
	word_t wdata;

	// Grant and response, driven by the slave
	logic  gnt;
	word_t rdata;
	// One cycle after acceptance, for loads and stores
	logic  rvalid;

	modport master (
		output req, addr, we, be, wdata,
		input  gnt, rdata, rvalid
	);

	modport slave (
		input  req, addr, we, be, wdata,
		output gnt, rdata, rvalid
	);

endinterface

/* hw/lsu.sv */
// Load/store unit: bus request build-up, byte enables, load type capture, load extension
`timescale 1ns/1ps

module lsu (
	input  logic                       clk_i,
	input  logic                       rst_n_i,

	// Command from the writeback stage
	input  riscv_defines::word_t       data_addr_i,
	input  riscv_defines::word_t       data_wdata_i,
	input  logic                       load_flag_i,
	input  riscv_defines::load_type_t  load_type_i,
	input  logic                       store_flag_i,
	input  riscv_defines::store_type_t store_type_i,
	output riscv_defines::word_t       load_data_o,
	output logic                       load_valid_o,
	output logic                       req_gnt_o,

	// Data memory bus
	mem_bus_if.master                  bus
);
	import riscv_defines::*;

	be_t        store_be;
	be_t        load_be;
	logic       accept;
	// Load in flight, response due next cycle
	logic       load_pend_q;
	load_type_t load_type_q;

	//////////////////////////////
	// Request side
	//////////////////////////////

	assign bus.req   = load_flag_i | store_flag_i;
	assign bus.addr  = data_addr_i;
	assign bus.we    = store_flag_i;
	assign bus.be    = store_flag_i ? store_be : load_be;
	assign bus.wdata = data_wdata_i;

	assign accept    = bus.req & bus.gnt;
	assign req_gnt_o = accept;

	// Store lanes
	always_comb begin
		case (store_type_i)
			ST_SB:   store_be = BE_BYTE;
			ST_SH:   store_be = BE_HALF;
			ST_SW:   store_be = BE_WORD;
			default: store_be = BE_NONE;
		endcase
	end

	// Load lanes, signed and unsigned share a width
	always_comb begin
		case (load_type_i)
			LD_LB, LD_LBU: load_be = BE_BYTE;
			LD_LH, LD_LHU: load_be = BE_HALF;
			LD_LW:         load_be = BE_WORD;
			default:       load_be = BE_NONE;
		endcase
	end

	//////////////////////////////
	// Response side
	//////////////////////////////

	// Pending bit tracks whether the next rvalid belongs to a load
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			load_pend_q <= 1'b0;
		end else if (accept) begin
			load_pend_q <= load_flag_i;
		end else if (bus.rvalid) begin
			load_pend_q <= 1'b0;
		end
	end

	// Type captured so the core strobes its command for one cycle only
	always_ff @(posedge clk_i) begin
		if (accept && load_flag_i) begin
			load_type_q <= load_type_i;
		end
	end

	assign load_valid_o = bus.rvalid & load_pend_q;

	// Extension from the low lanes, no offset shift
	always_comb begin
		case (load_type_q)
			LD_LB:   load_data_o = {{(WORD_WIDTH-8){bus.rdata[7]}}, bus.rdata[7:0]};
			LD_LBU:  load_data_o = {{(WORD_WIDTH-8){1'b0}}, bus.rdata[7:0]};
			LD_LH:   load_data_o = {{(WORD_WIDTH-16){bus.rdata[15]}}, bus.rdata[15:0]};
			LD_LHU:  load_data_o = {{(WORD_WIDTH-16){1'b0}}, bus.rdata[15:0]};
			default: load_data_o = bus.rdata;
		endcase
	end

	// One command kind per strobe from the core
	a_flags_exclusive: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		!(load_flag_i && store_flag_i));

endmodule

/* hw/data_ram.sv */
// Data RAM target: word-indexed storage, byte-lane writes, registered read response
`timescale 1ns/1ps

module data_ram #(
	parameter int unsigned RAM_WORDS = 256
) (
	input  logic     clk_i,
	input  logic     rst_n_i,
	mem_bus_if.slave bus
);
	import riscv_defines::*;

	localparam int unsigned IDX_W = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;

	// Storage, contents undefined after reset
	word_t            mem [RAM_WORDS];
	logic [IDX_W-1:0] word_idx;
	logic             accept;
	word_t            rdata_q;
	logic             rvalid_q;

	// No wait states
	assign bus.gnt  = bus.req;
	assign accept   = bus.req & bus.gnt;

	// Byte offset bits dropped
	assign word_idx = bus.addr[IDX_W+1:2];

	//////////////////////////////
	// Write port
	//////////////////////////////

	// Only enabled lanes change
	always_ff @(posedge clk_i) begin
		if (accept && bus.we) begin
			for (int lane = 0; lane < BE_WIDTH; lane++) begin
				if (bus.be[lane]) begin
					mem[word_idx][8*lane +: 8] <= bus.wdata[8*lane +: 8];
				end
			end
		end
	end

	//////////////////////////////
	// Read response
	//////////////////////////////

	// Whole word for loads, zero for stores
	always_ff @(posedge clk_i) begin
		if (accept) begin
			rdata_q <= bus.we ? '0 : mem[word_idx];
		end
	end

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			rvalid_q <= 1'b0;
		end else begin
			rvalid_q <= accept;
		end
	end

	assign bus.rdata  = rdata_q;
	assign bus.rvalid = rvalid_q;

	// Full word address, upper bits included, stays inside the array
	a_index_in_range: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		accept |-> (bus.addr[WORD_WIDTH-1:2] < RAM_WORDS));

endmodule

/* hw/mmio_timer.sv */
// Machine timer target: control, mtime and mtimecmp registers, status read, compare interrupt
`timescale 1ns/1ps

`include "mem_map.svh"

module mmio_timer (
	input  logic     clk_i,
	input  logic     rst_n_i,
	mem_bus_if.slave bus,
	output logic     timer_irq_o
);
	import riscv_defines::*;

	logic [`TMR_OFF_W-1:0] offset;
	logic                  accept;
	logic                  wr_en;
	logic                  irq;
	word_t                 ctrl_q;
	word_t                 mtime_q;
	word_t                 mtimecmp_q;
	word_t                 rd_mux;
	word_t                 rdata_q;
	logic                  rvalid_q;

	assign bus.gnt = bus.req;
	assign accept  = bus.req & bus.gnt;
	assign wr_en   = accept & bus.we;
	// Higher address bits alias onto the same registers
	assign offset  = bus.addr[`TMR_OFF_W-1:0];

	//////////////////////////////
	// Registers
	//////////////////////////////

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ctrl_q     <= '0;
			mtime_q    <= '0;
			mtimecmp_q <= '0;
		end else begin
			if (wr_en && offset == `TMR_CTRL) begin
				ctrl_q <= bus.wdata;
			end
			// Software write wins over the tick
			if (wr_en && offset == `TMR_MTIME) begin
				mtime_q <= bus.wdata;
			end else if (ctrl_q[0]) begin
				mtime_q <= mtime_q + 1'b1;
			end
			if (wr_en && offset == `TMR_MTIMECMP) begin
				mtimecmp_q <= bus.wdata;
			end
		end
	end

	// Level interrupt, held off while the compare value is zero
	assign irq         = (mtime_q >= mtimecmp_q) && (mtimecmp_q != '0);
	assign timer_irq_o = irq;

	//////////////////////////////
	// Read response
	//////////////////////////////

	always_comb begin
		case (offset)
			`TMR_CTRL:     rd_mux = ctrl_q;
			`TMR_MTIME:    rd_mux = mtime_q;
			`TMR_MTIMECMP: rd_mux = mtimecmp_q;
			`TMR_STATUS:   rd_mux = {{(WORD_WIDTH-1){1'b0}}, irq};
			// Unmapped offsets
			default:       rd_mux = '0;
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (accept) begin
			rdata_q <= bus.we ? '0 : rd_mux;
		end
	end

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			rvalid_q <= 1'b0;
		end else begin
			rvalid_q <= accept;
		end
	end

	assign bus.rdata  = rdata_q;
	assign bus.rvalid = rvalid_q;

	// Registers are word-wide, partial stores from the LSU would corrupt them
	a_full_word_write: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		wr_en |-> (bus.be == BE_WORD));

endmodule

/* hw/data_bus_xbar.sv */
// Data bus fabric: address decode to RAM or timer, grant return, registered response select
`timescale 1ns/1ps

`include "mem_map.svh"

module data_bus_xbar (
	input  logic      clk_i,
	input  logic      rst_n_i,
	mem_bus_if.slave  cpu,
	mem_bus_if.master ram,
	mem_bus_if.master tmr
);
	logic sel_tmr;
	logic accept;
	// Target of the request accepted last cycle
	logic sel_tmr_q;

	//////////////////////////////
	// Request routing
	//////////////////////////////

	assign sel_tmr  = cpu.addr[`MMIO_SEL_BIT];

	// Only the chosen target sees req
	assign ram.req  = cpu.req & ~sel_tmr;
	assign tmr.req  = cpu.req & sel_tmr;

	// Payload shared, qualified by req
	assign ram.addr  = cpu.addr;
	assign ram.we    = cpu.we;
	assign ram.be    = cpu.be;
	assign ram.wdata = cpu.wdata;
	assign tmr.addr  = cpu.addr;
	assign tmr.we    = cpu.we;
	assign tmr.be    = cpu.be;
	assign tmr.wdata = cpu.wdata;

	assign cpu.gnt  = sel_tmr ? tmr.gnt : ram.gnt;
	assign accept   = cpu.req & cpu.gnt;

	//////////////////////////////
	// Response merge
	//////////////////////////////

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			sel_tmr_q <= 1'b0;
		end else if (accept) begin
			sel_tmr_q <= sel_tmr;
		end
	end

	assign cpu.rvalid = sel_tmr_q ? tmr.rvalid : ram.rvalid;
	assign cpu.rdata  = sel_tmr_q ? tmr.rdata : ram.rdata;

	// Single outstanding request, so responses cannot collide
	a_one_responder: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		!(ram.rvalid && tmr.rvalid));

	// Each accepted request gets its response in the next cycle
	a_response_next: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		accept |=> cpu.rvalid);

endmodule

/* hw/data_subsys_top.sv */
// Data subsystem top: LSU, bus fabric, data RAM and machine timer on plain ports
`timescale 1ns/1ps

module data_subsys_top #(
	parameter int unsigned RAM_WORDS = 256
) (
	input  logic                       clk_i,
	input  logic                       rst_n_i,

	// Command from the writeback stage
	input  riscv_defines::word_t       addr_i,
	input  riscv_defines::word_t       wdata_i,
	input  logic                       load_flag_i,
	input  logic                       store_flag_i,
	input  riscv_defines::load_type_t  load_type_i,
	input  riscv_defines::store_type_t store_type_i,

	// Results back to the core
	output riscv_defines::word_t       load_data_o,
	output logic                       load_valid_o,
	output logic                       req_gnt_o,
	output logic                       timer_irq_o
);

	// LSU to fabric, fabric to each target
	mem_bus_if lsu_bus ();
	mem_bus_if ram_bus ();
	mem_bus_if tmr_bus ();

	lsu u_lsu (
		.clk_i        (clk_i),
		.rst_n_i      (rst_n_i),
		.data_addr_i  (addr_i),
		.data_wdata_i (wdata_i),
		.load_flag_i  (load_flag_i),
		.load_type_i  (load_type_i),
		.store_flag_i (store_flag_i),
		.store_type_i (store_type_i),
		.load_data_o  (load_data_o),
		.load_valid_o (load_valid_o),
		.req_gnt_o    (req_gnt_o),
		.bus          (lsu_bus.master)
	);

	data_bus_xbar u_xbar (
		.clk_i   (clk_i),
		.rst_n_i (rst_n_i),
		.cpu     (lsu_bus.slave),
		.ram     (ram_bus.master),
		.tmr     (tmr_bus.master)
	);

	data_ram #(
		.RAM_WORDS (RAM_WORDS)
	) u_ram (
		.clk_i   (clk_i),
		.rst_n_i (rst_n_i),
		.bus     (ram_bus.slave)
	);

	mmio_timer u_timer (
		.clk_i       (clk_i),
		.rst_n_i     (rst_n_i),
		.bus         (tmr_bus.slave),
		.timer_irq_o (timer_irq_o)
	);

endmodule

/* dv/tb_data_subsys.sv */
// Testbench for the data subsystem with RAM reference model, load extension checks and timer scenario
`timescale 1ns/1ps

`include "mem_map.svh"

module tb_data_subsys;
	import riscv_defines::*;

	localparam int unsigned RAM_WORDS   = 256;
	localparam int unsigned GNT_TIMEOUT = 10;
	localparam int unsigned RSP_TIMEOUT = 10;
	localparam int unsigned IRQ_TIMEOUT = 200;
	// Timer window starts at the select bit
	localparam word_t       TMR_BASE    = 32'h1 << `MMIO_SEL_BIT;

	logic        clk;
	logic        rst_n;
	word_t       addr;
	word_t       wdata;
	logic        load_flag;
	logic        store_flag;
	load_type_t  load_type;
	store_type_t store_type;
	word_t       load_data;
	logic        load_valid;
	logic        req_gnt;
	logic        timer_irq;

	// Reference RAM and indices of words holding known data
	word_t ref_mem [RAM_WORDS];
	int    written_q [$];
	// Outstanding loads with expected value, test name and acceptance cycle
	word_t exp_q [$];
	string name_q [$];
	word_t acc_q [$];
	word_t cyc = '0;

	data_subsys_top #(
		.RAM_WORDS (RAM_WORDS)
	) dut (
		.clk_i        (clk),
		.rst_n_i      (rst_n),
		.addr_i       (addr),
		.wdata_i      (wdata),
		.load_flag_i  (load_flag),
		.store_flag_i (store_flag),
		.load_type_i  (load_type),
		.store_type_i (store_type),
		.load_data_o  (load_data),
		.load_valid_o (load_valid),
		.req_gnt_o    (req_gnt),
		.timer_irq_o  (timer_irq)
	);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	// Cycle count for the load latency check
	always @(posedge clk) cyc <= cyc + 1;

	//////////////////////////////
	// Reference model
	//////////////////////////////

	// Expected load result from the low lanes only
	function automatic word_t ext_load(word_t w, load_type_t lt);
		case (lt)
			LD_LB:   return {{24{w[7]}}, w[7:0]};
			LD_LBU:  return {24'h0, w[7:0]};
			LD_LH:   return {{16{w[15]}}, w[15:0]};
			LD_LHU:  return {16'h0, w[15:0]};
			default: return w;
		endcase
	endfunction

	// Stored word after a byte, halfword or word store
	function automatic word_t merge_store(word_t old, word_t d, store_type_t st);
		case (st)
			ST_SB:   return {old[31:8], d[7:0]};
			ST_SH:   return {old[31:16], d[15:0]};
			default: return d;
		endcase
	endfunction

	// Interrupt level is off while the compare value is zero
	function automatic logic irq_ref(word_t mtime, word_t cmp);
		return (cmp != 0) && (mtime >= cmp);
	endfunction

	//////////////////////////////
	// Checks and bus tasks
	//////////////////////////////

	task automatic check_value(string name, word_t exp, word_t act);
		if (exp !== act) begin
			$display("CHECK FAILED %s expected %h actual %h", name, exp, act);
			$display("TEST RESULT: FAIL");
			$fatal(1, "stopping at first mismatch");
		end
	endtask

	task automatic report_timeout(string what);
		$display("Timeout while waiting for %s", what);
		$display("TEST RESULT: FAIL");
		$fatal(1, "wait timed out");
	endtask

	// Returns at the posedge where the command is accepted
	task automatic await_grant(string what);
		int waited;
		waited = 0;
		@(posedge clk);
		while (!req_gnt) begin
			if (waited == GNT_TIMEOUT) begin
				report_timeout({what, " grant"});
			end
			@(posedge clk);
			waited++;
		end
	endtask

	task automatic send_store(word_t a, word_t d, store_type_t st);
		@(negedge clk);
		addr       = a;
		wdata      = d;
		store_type = st;
		store_flag = 1'b1;
		await_grant("store");
		// Only RAM stores update the reference memory
		if (!a[`MMIO_SEL_BIT]) begin
			ref_mem[(a >> 2) % RAM_WORDS] = merge_store(ref_mem[(a >> 2) % RAM_WORDS], d, st);
		end
		@(negedge clk);
		store_flag = 1'b0;
	endtask

	task automatic fetch_load(string name, word_t a, load_type_t lt, word_t exp);
		int waited;
		@(negedge clk);
		addr      = a;
		load_type = lt;
		load_flag = 1'b1;
		await_grant(name);
		exp_q.push_back(exp);
		name_q.push_back(name);
		acc_q.push_back(cyc);
		@(negedge clk);
		load_flag = 1'b0;
		// Response is checked by the compare process
		waited = 0;
		while (exp_q.size() != 0) begin
			if (waited == RSP_TIMEOUT) begin
				report_timeout({name, " load response"});
			end
			@(posedge clk);
			waited++;
		end
	endtask

	// Compares each load response at the falling edge
	always @(negedge clk) begin
		if (rst_n && load_valid) begin
			if (exp_q.size() == 0) begin
				$display("Error: load_valid_o high with no load outstanding");
				$display("TEST RESULT: FAIL");
				$fatal(1, "unexpected load response");
			end else begin
				check_value({name_q[0], " latency"}, acc_q[0] + 1, cyc);
				check_value(name_q[0], exp_q[0], load_data);
				void'(exp_q.pop_front());
				void'(name_q.pop_front());
				void'(acc_q.pop_front());
			end
		end
	end

	//////////////////////////////
	// Stimulus
	//////////////////////////////

	initial begin
		word_t data;
		word_t mt;
		word_t cmp;
		int    idx;
		int    waited;
		void'($urandom(22));
		rst_n      = 1'b0;
		addr       = '0;
		wdata      = '0;
		load_flag  = 1'b0;
		store_flag = 1'b0;
		load_type  = LD_LW;
		store_type = ST_SW;
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		// Idle outputs after reset
		check_value("reset load_valid", 0, load_valid);
		check_value("reset timer_irq", 0, timer_irq);
		check_value("idle req_gnt", 0, req_gnt);

		// Word store then word load
		for (int i = 0; i < 8; i++) begin
			idx  = $urandom % RAM_WORDS;
			data = $urandom;
			send_store(idx << 2, data, ST_SW);
			fetch_load("sw lw", idx << 2, LD_LW, ext_load(ref_mem[idx], LD_LW));
			written_q.push_back(idx);
		end

		// Partial stores on known words merge into the low lanes
		for (int i = 0; i < 4; i++) begin
			idx = written_q[$urandom % written_q.size()];
			send_store(idx << 2, $urandom, ST_SB);
			fetch_load("sb lw", idx << 2, LD_LW, ref_mem[idx]);
			send_store(idx << 2, $urandom, ST_SH);
			fetch_load("sh lw", idx << 2, LD_LW, ref_mem[idx]);
		end

		// Sign and zero extension with alternating sign bits
		for (int i = 0; i < 8; i++) begin
			idx      = $urandom % RAM_WORDS;
			data     = $urandom;
			data[7]  = i[0];
			data[15] = i[0];
			send_store(idx << 2, data, ST_SW);
			written_q.push_back(idx);
			fetch_load("lb", idx << 2, LD_LB, ext_load(ref_mem[idx], LD_LB));
			fetch_load("lbu", idx << 2, LD_LBU, ext_load(ref_mem[idx], LD_LBU));
			fetch_load("lh", idx << 2, LD_LH, ext_load(ref_mem[idx], LD_LH));
			fetch_load("lhu", idx << 2, LD_LHU, ext_load(ref_mem[idx], LD_LHU));
		end

		// Known data in the RAM words that the timer offsets alias onto
		for (int i = 0; i < 3; i++) begin
			send_store(i << 2, $urandom, ST_SW);
			written_q.push_back(i);
		end

		// Timer registers with the counter stopped
		mt  = 100 + ($urandom % 1000);
		cmp = mt + 50;
		fetch_load("ctrl", TMR_BASE + `TMR_CTRL, LD_LW, 0);
		send_store(TMR_BASE + `TMR_MTIME, mt, ST_SW);
		fetch_load("mtime", TMR_BASE + `TMR_MTIME, LD_LW, mt);
		send_store(TMR_BASE + `TMR_MTIMECMP, cmp, ST_SW);
		fetch_load("mtimecmp", TMR_BASE + `TMR_MTIMECMP, LD_LW, cmp);
		fetch_load("status below", TMR_BASE + `TMR_STATUS, LD_LW, irq_ref(mt, cmp));
		check_value("irq below", irq_ref(mt, cmp), timer_irq);
		cmp = mt - 50;
		send_store(TMR_BASE + `TMR_MTIMECMP, cmp, ST_SW);
		fetch_load("status above", TMR_BASE + `TMR_STATUS, LD_LW, irq_ref(mt, cmp));
		check_value("irq above", irq_ref(mt, cmp), timer_irq);
		send_store(TMR_BASE + `TMR_MTIMECMP, 0, ST_SW);
		fetch_load("status zero cmp", TMR_BASE + `TMR_STATUS, LD_LW, irq_ref(mt, 0));

		// Counter running with the compare value a few counts ahead
		send_store(TMR_BASE + `TMR_MTIMECMP, mt + 8, ST_SW);
		check_value("irq before enable", 0, timer_irq);
		send_store(TMR_BASE + `TMR_CTRL, 1, ST_SW);
		waited = 0;
		while (!timer_irq) begin
			if (waited == IRQ_TIMEOUT) begin
				report_timeout("timer interrupt");
			end
			@(negedge clk);
			waited++;
		end
		fetch_load("status irq", TMR_BASE + `TMR_STATUS, LD_LW, 1);

		// RAM untouched by timer traffic
		foreach (written_q[i]) begin
			fetch_load("ram after timer", written_q[i] << 2, LD_LW, ref_mem[written_q[i]]);
		end

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

/* verilog.f */
+incdir+include
hw/riscv_defines.sv
hw/mem_bus_if.sv
hw/lsu.sv
hw/data_ram.sv
hw/mmio_timer.sv
hw/data_bus_xbar.sv
hw/data_subsys_top.sv
dv/tb_data_subsys.sv
